//--- build.f
design/fetch_pkg.sv
design/ctrl_pkg.sv
design/pc_predict.sv
design/fetch_fsm.sv
design/credit_counter.sv
design/fetch_output.sv
design/fetch_top.sv
verif/fetch_properties.sv
verif/fetch_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the fetch testbench with verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
    -f build.f -Mdir "$OBJ" -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"$OBJ"/fetch_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam int N_CYCLES = 3000;
    localparam fetch_pkg::addr_t KEY = 32'h5a5a_0000;  // memory word is addr ^ key.

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    fetch_pkg::addr_t  req_addr;
    logic              req_ready;
    logic              rsp_valid;
    fetch_pkg::instr_t rsp_data;
    logic              out_valid;
    fetch_pkg::addr_t  out_pc;
    fetch_pkg::instr_t out_instr;
    logic              credit_return;
    logic              redirect_valid;
    fetch_pkg::addr_t  redirect_pc;
    logic              hold;

    integer            seed;
    int                mismatches;
    int                failures;
    fetch_pkg::addr_t  exp_pc;      // next pc decode should see.
    fetch_pkg::addr_t  read_q[$];   // reads the memory has taken.
    int                ready_wait;
    int                rsp_wait;
    int                ret_wait;
    int                held;        // delivered and not yet returned.
    int                delivered;
    int                full_cycles; // cycles with every slot held.
    logic              prev_req_valid;
    logic              seen_req;
    logic              seen_rsp;

    fetch_top i_dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    task automatic flag_mismatch(input string msg);
        mismatches++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic flag_failure(input string msg);
        failures++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // outputs settled since the last rising edge.
    task automatic check_outputs();
        if (out_valid) begin
            if (!seen_rsp) flag_failure("out_valid rose before any memory response");
            if (out_pc !== exp_pc)
                flag_mismatch($sformatf("out_pc %h, expected %h", out_pc, exp_pc));
            if (out_instr !== (exp_pc ^ KEY))
                flag_mismatch($sformatf("out_instr %h, expected %h",
                                        out_instr, exp_pc ^ KEY));
            exp_pc = exp_pc + 32'd4;
            held++;
            delivered++;
            if (held > ctrl_pkg::MAX_CREDITS)
                flag_failure("decode holds more instructions than it has slots");
        end
        if (held == ctrl_pkg::MAX_CREDITS) full_cycles++;
        if (req_valid && !prev_req_valid) begin
            if (hold) flag_failure("request raised after a cycle with hold high");
            if (!seen_req && req_addr !== fetch_pkg::RESET_PC)
                flag_mismatch($sformatf("first request at %h", req_addr));
            seen_req = 1'b1;
        end
        prev_req_valid = req_valid;
    endtask

    task automatic drive_memory();
        rsp_valid = 1'b0;
        if (read_q.size() != 0) begin
            if (rsp_wait == 0) begin
                rsp_valid = 1'b1;
                rsp_data  = read_q.pop_front() ^ KEY;
                seen_rsp  = 1'b1;
            end else
                rsp_wait--;
        end
        req_ready = 1'b0;
        if (req_valid) begin
            if (ready_wait == 0) begin
                req_ready = 1'b1;  // taken on the coming edge.
                if (held >= ctrl_pkg::MAX_CREDITS)
                    flag_failure("request accepted with no free decode slot");
                read_q.push_back(req_addr);
                rsp_wait   = rand_below(4);
                ready_wait = rand_below(4);
            end else
                ready_wait--;
        end
    endtask

    task automatic drive_decode();
        credit_return = 1'b0;
        if (held > 0) begin
            if (ret_wait == 0) begin
                credit_return = 1'b1;
                held--;
                // now and then decode sits on its slots a while.
                ret_wait = (rand_below(8) == 0) ? 40 + rand_below(40) : rand_below(3);
            end else
                ret_wait--;
        end
    endtask

    task automatic drive_control();
        if (rand_below(8) == 0) hold = ~hold;
        redirect_valid = 1'b0;
        if (seen_req && rand_below(24) == 0) begin
            redirect_valid = 1'b1;
            redirect_pc    = fetch_pkg::RESET_PC + fetch_pkg::addr_t'(rand_below(4096) * 4);
            exp_pc         = redirect_pc;  // whatever is in flight is stale.
        end
    endtask

    initial begin
        seed           = 32'haae3;
        mismatches     = 0;
        failures       = 0;
        rst_n          = 1'b0;
        req_ready      = 1'b0;
        rsp_valid      = 1'b0;
        rsp_data       = '0;
        credit_return  = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        hold           = 1'b0;
        exp_pc         = fetch_pkg::RESET_PC;
        ready_wait     = rand_below(4);
        rsp_wait       = 0;
        ret_wait       = 0;
        held           = 0;
        delivered      = 0;
        full_cycles    = 0;
        prev_req_valid = 1'b0;
        seen_req       = 1'b0;
        seen_rsp       = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
            @(negedge clk);
            check_outputs();
            drive_memory();
            drive_decode();
            drive_control();
        end
        if (delivered < N_CYCLES / 40)
            flag_failure($sformatf("only %0d instructions delivered", delivered));
        if (full_cycles == 0)
            flag_failure("decode slots never ran out, credit stall not reached");
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, i_dut.i_props.assert_fails);
        if (mismatches == 0 && failures == 0 && i_dut.i_props.assert_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // bound on the whole run.
    initial begin
        #(N_CYCLES * 4 * 20);
        $display("timeout, stimulus of %0d cycles did not complete", N_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- verif/fetch_properties.sv
`timescale 1ns/1ps

module fetch_properties (
    input logic             clk,
    input logic             rst_n,
    input logic             req_valid,
    input logic             req_ready,
    input fetch_pkg::addr_t req_addr,
    input logic             rsp_valid,
    input logic             out_valid,
    input logic             redirect_valid
);

    int req_fails = 0;
    int addr_fails = 0;
    int out_fails = 0;
    int assert_fails;

    assign assert_fails = req_fails + addr_fails + out_fails;

    req_kept: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid)
        else begin
            req_fails = req_fails + 1;
            $error("request withdrawn before the memory took it");
        end

    // a redirect may retarget a raised request.
    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready && !redirect_valid |=> req_addr == $past(req_addr))
        else begin
            addr_fails = addr_fails + 1;
            $error("req_addr changed while waiting for req_ready");
        end

    out_after_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(rsp_valid))
        else begin
            out_fails = out_fails + 1;
            $error("out_valid without a response the cycle before");
        end

endmodule

bind fetch_top fetch_properties i_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_addr       (req_addr),
    .rsp_valid      (rsp_valid),
    .out_valid      (out_valid),
    .redirect_valid (redirect_valid)
);

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic              clk,
    input  logic              rst_n,
    output logic              req_valid,
    output fetch_pkg::addr_t  req_addr,
    input  logic              req_ready,
    input  logic              rsp_valid,
    input  fetch_pkg::instr_t rsp_data,
    output logic              out_valid,
    output fetch_pkg::addr_t  out_pc,
    output fetch_pkg::instr_t out_instr,
    input  logic              credit_return,
    input  logic              redirect_valid,
    input  fetch_pkg::addr_t  redirect_pc,
    input  logic              hold
);

    logic fire;
    logic done;
    logic has_credit;
    logic drop_credit;

    // the pc register is the request address.
    pc_predict i_pc_predict (
        .clk            (clk),
        .rst_n          (rst_n),
        .fire           (fire),
        .done           (done),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc             (req_addr)
    );

    fetch_fsm i_fetch_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .has_credit (has_credit),
        .hold       (hold),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .req_valid  (req_valid),
        .fire       (fire),
        .done       (done)
    );

    credit_counter i_credit_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .fire          (fire),
        .credit_return (credit_return),
        .drop_credit   (drop_credit),
        .has_credit    (has_credit)
    );

    fetch_output i_fetch_output (
        .clk            (clk),
        .rst_n          (rst_n),
        .fire           (fire),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .req_pc         (req_addr),
        .redirect_valid (redirect_valid),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_instr      (out_instr),
        .drop_credit    (drop_credit)
    );

endmodule

//--- design/fetch_output.sv
`timescale 1ns/1ps

module fetch_output (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fire,
    input  logic              rsp_valid,
    input  fetch_pkg::instr_t rsp_data,
    input  fetch_pkg::addr_t  req_pc,
    input  logic              redirect_valid,
    output logic              out_valid,
    output fetch_pkg::addr_t  out_pc,
    output fetch_pkg::instr_t out_instr,
    output logic              drop_credit
);

    fetch_pkg::addr_t cap_pc;   // address of the read in flight.
    logic             stale;
    logic             keep;

    // a redirect in the response cycle also kills the word.
    assign keep = rsp_valid & ~stale & ~redirect_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stale       <= 1'b0;
            out_valid   <= 1'b0;
            drop_credit <= 1'b0;
        end else begin
            if (fire) begin
                stale <= redirect_valid;   // redirect on the accept cycle counts.
            end else if (redirect_valid) begin
                stale <= 1'b1;
            end
            out_valid   <= keep;
            drop_credit <= rsp_valid & ~keep;  // slot goes back to the counter.
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            cap_pc <= req_pc;
        end
        if (keep) begin
            out_pc    <= cap_pc;
            out_instr <= rsp_data;
        end
    end

endmodule

//--- design/credit_counter.sv
`timescale 1ns/1ps

module credit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic fire,
    input  logic credit_return,
    input  logic drop_credit,
    output logic has_credit
);

    localparam fetch_pkg::credit_t CREDIT_MAX = fetch_pkg::credit_t'(ctrl_pkg::MAX_CREDITS);

    fetch_pkg::credit_t count;
    fetch_pkg::credit_t count_up;
    fetch_pkg::credit_t count_next;

    // return and drop can land together.
    assign count_up = count + fetch_pkg::credit_t'(credit_return)
                            + fetch_pkg::credit_t'(drop_credit);

    always_comb begin
        count_next = count_up;
        if (fire && count_up != '0) begin
            count_next = count_up - 1'b1;
        end
        if (count_next > CREDIT_MAX) begin
            count_next = CREDIT_MAX;       // clip at the granted depth.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= CREDIT_MAX;
        end else begin
            count <= count_next;
        end
    end

    assign has_credit = (count != '0);

endmodule

//--- design/fetch_fsm.sv
`timescale 1ns/1ps

module fetch_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic has_credit,
    input  logic hold,
    input  logic req_ready,
    input  logic rsp_valid,
    output logic req_valid,
    output logic fire,
    output logic done
);

    ctrl_pkg::fetch_state_t state;
    ctrl_pkg::fetch_state_t state_next;
    logic                   can_start;

    // a new read needs a free decode slot and no hold.
    assign can_start = has_credit & ~hold;

    always_comb begin
        state_next = state;
        unique case (state)
            ctrl_pkg::IDLE: begin
                if (can_start) begin
                    state_next = ctrl_pkg::REQ;
                end
            end
            ctrl_pkg::REQ: begin
                // stays raised until the memory takes it.
                if (req_ready) begin
                    state_next = ctrl_pkg::WAIT;
                end
            end
            ctrl_pkg::WAIT: begin
                if (rsp_valid) begin
                    state_next = ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_next = ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ctrl_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign req_valid = (state == ctrl_pkg::REQ);
    assign fire      = req_valid & req_ready;                     // request accepted.
    assign done      = (state == ctrl_pkg::WAIT) & rsp_valid;     // one response per read.

endmodule

//--- design/pc_predict.sv
`timescale 1ns/1ps

module pc_predict #(
    parameter fetch_pkg::addr_t reset_pc = fetch_pkg::RESET_PC
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fire,
    input  logic             done,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    output fetch_pkg::addr_t pc
);

    logic             busy;        // read accepted, response not yet seen.
    logic             pend_valid;
    fetch_pkg::addr_t pend_pc;     // redirect target held for done.
    fetch_pkg::addr_t pc_next;
    logic             in_flight;

    // the accepting cycle already used the old pc.
    assign in_flight = busy | fire;

    always_comb begin
        pc_next = pc;
        if (done) begin
            if (redirect_valid) begin
                pc_next = redirect_pc;     // newest redirect wins.
            end else if (pend_valid) begin
                pc_next = pend_pc;
            end else begin
                pc_next = pc + fetch_pkg::PC_STEP;
            end
        end else if (redirect_valid && !in_flight) begin
            // nothing accepted yet so retarget right away.
            pc_next = redirect_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= reset_pc;
            busy       <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            pc <= pc_next;
            if (fire) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (done) begin
                pend_valid <= 1'b0;
            end else if (redirect_valid && in_flight) begin
                pend_valid <= 1'b1;
            end
        end
    end

    // target of a redirect seen while a read is out.
    always_ff @(posedge clk) begin
        if (redirect_valid && in_flight && !done) begin
            pend_pc <= redirect_pc;
        end
    end

endmodule

//--- design/ctrl_pkg.sv
package ctrl_pkg;

    // fetch sequencing.
    // IDLE waits for a credit and no hold,
    // REQ holds the read request until the memory takes it,
    // WAIT covers the read in flight.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        REQ  = 2'd1,
        WAIT = 2'd2
    } fetch_state_t;

    // decode slots granted after reset.
    localparam int MAX_CREDITS = 4;

endpackage

//--- design/fetch_pkg.sv
package fetch_pkg;

    // datapath widths of the fetch front end.
    localparam int ADDR_W   = 32;
    localparam int INSTR_W  = 32;
    localparam int CREDIT_W = 3;

    typedef logic [ADDR_W-1:0]   addr_t;   // instruction address.
    typedef logic [INSTR_W-1:0]  instr_t;  // raw instruction word.
    typedef logic [CREDIT_W-1:0] credit_t; // decode slot count.

    // pc after reset.
    localparam addr_t RESET_PC = 32'h8000_0000;

    // sequential step for uncompressed code.
    localparam addr_t PC_STEP = 32'd4;

endpackage
